// ==== logic/rmt_pkg.sv ====
`default_nettype none

package rmt_pkg;

    // container classes
    localparam int NUM_CONT = 4;
    localparam int C6_W     = 48;
    localparam int C4_W     = 32;
    localparam int C2_W     = 16;
    localparam int META_W   = 32;
    localparam int PHV_W    = NUM_CONT * (C6_W + C4_W + C2_W) + META_W;

    // phv layout, metadata sits in the lowest bits
    localparam int C2_LSB = META_W;
    localparam int C4_LSB = C2_LSB + NUM_CONT * C2_W;
    localparam int C6_LSB = C4_LSB + NUM_CONT * C4_W;

    // lookup key is the low nibble of 2B container 0
    localparam int KEY_W = 4;

    // action word fields
    localparam int ACT_W    = 25;
    localparam int OPC_LSB  = 21;
    localparam int OPC_W    = 4;
    localparam int SRCA_LSB = 19;
    localparam int SRCB_LSB = 17;
    localparam int IDX_W    = 2;
    localparam int IMM_LSB  = 0;
    localparam int IMM_W    = 16;

    // word 12 is metadata, then 6B, 4B, 2B groups of four
    localparam int NUM_ACT  = 13;
    localparam int ACTV_W   = NUM_ACT * ACT_W;
    localparam int META_ACT = NUM_ACT - 1;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP     = 4'd0,
        OP_COPY    = 4'd1,
        OP_ADD     = 4'd2,
        OP_SUB     = 4'd3,
        OP_ADDI    = 4'd4,
        OP_SETI    = 4'd5,
        OP_DISCARD = 4'd6
    } alu_op_e;

    typedef logic [C6_W-1:0] cont6_t;
    typedef logic [C4_W-1:0] cont4_t;
    typedef logic [C2_W-1:0] cont2_t;

    // true when a container ALU leaves its container alone
    function automatic logic keeps_container(logic [OPC_W-1:0] op);
        return !(op inside {OP_COPY, OP_ADD, OP_SUB, OP_ADDI, OP_SETI});
    endfunction

endpackage

`default_nettype wire

// ==== logic/action_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_lookup
    import rmt_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           adv_i,
    input  logic [PHV_W-1:0]               phv_i,
    input  logic                           phv_valid_i,
    input  logic                           tbl_wr_en_i,
    input  logic [$clog2(TABLE_DEPTH)-1:0] tbl_wr_addr_i,
    input  logic [ACTV_W-1:0]              tbl_wr_data_i,
    output logic [PHV_W-1:0]               phv_o,
    output logic                           phv_valid_o,
    output logic [ACTV_W-1:0]              action_o
);

    logic [ACTV_W-1:0] act_table [TABLE_DEPTH];
    logic [KEY_W-1:0]  key;

    assign key = phv_i[C2_LSB +: KEY_W];

    // writes land on the edge, so a lookup on the same edge still sees the old entry
    always_ff @(posedge clk) begin
        if (tbl_wr_en_i) begin
            act_table[tbl_wr_addr_i] <= tbl_wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phv_valid_o <= 1'b0;
        end else if (adv_i) begin
            phv_valid_o <= phv_valid_i;
        end
    end

    // phv delayed to line up with the table read
    always_ff @(posedge clk) begin
        if (adv_i) begin
            phv_o    <= phv_i;
            action_o <= act_table[key];
        end
    end

    a_wr_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        tbl_wr_en_i |-> (tbl_wr_addr_i < TABLE_DEPTH)
    );

endmodule

`default_nettype wire

// ==== logic/action_crossbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_crossbar
    import rmt_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         adv_i,
    input  logic [PHV_W-1:0]             phv_i,
    input  logic                         phv_valid_i,
    input  logic [ACTV_W-1:0]            action_i,
    output cont6_t [NUM_CONT-1:0]        opa6_o,
    output cont6_t [NUM_CONT-1:0]        opb6_o,
    output cont4_t [NUM_CONT-1:0]        opa4_o,
    output cont4_t [NUM_CONT-1:0]        opb4_o,
    output cont2_t [NUM_CONT-1:0]        opa2_o,
    output cont2_t [NUM_CONT-1:0]        opb2_o,
    output logic   [META_W-1:0]          meta_o,
    output logic   [ACTV_W-1:0]          action_o,
    output logic                         valid_o
);

    cont6_t [NUM_CONT-1:0] c6;
    cont4_t [NUM_CONT-1:0] c4;
    cont2_t [NUM_CONT-1:0] c2;
    cont6_t [NUM_CONT-1:0] opa6_d;
    cont6_t [NUM_CONT-1:0] opb6_d;
    cont4_t [NUM_CONT-1:0] opa4_d;
    cont4_t [NUM_CONT-1:0] opb4_d;
    cont2_t [NUM_CONT-1:0] opa2_d;
    cont2_t [NUM_CONT-1:0] opb2_d;

    // split the phv into its width classes
    assign c6 = phv_i[C6_LSB +: NUM_CONT*C6_W];
    assign c4 = phv_i[C4_LSB +: NUM_CONT*C4_W];
    assign c2 = phv_i[C2_LSB +: NUM_CONT*C2_W];

    for (genvar k = 0; k < NUM_CONT; k++) begin : g_sel
        logic [ACT_W-1:0] act6;
        logic [ACT_W-1:0] act4;
        logic [ACT_W-1:0] act2;

        assign act6 = action_i[(2*NUM_CONT + k)*ACT_W +: ACT_W];
        assign act4 = action_i[(NUM_CONT + k)*ACT_W +: ACT_W];
        assign act2 = action_i[k*ACT_W +: ACT_W];

        // a kept container sees its own value on operand A
        assign opa6_d[k] = keeps_container(act6[OPC_LSB +: OPC_W]) ?
                           c6[k] : c6[act6[SRCA_LSB +: IDX_W]];
        assign opa4_d[k] = keeps_container(act4[OPC_LSB +: OPC_W]) ?
                           c4[k] : c4[act4[SRCA_LSB +: IDX_W]];
        assign opa2_d[k] = keeps_container(act2[OPC_LSB +: OPC_W]) ?
                           c2[k] : c2[act2[SRCA_LSB +: IDX_W]];

        assign opb6_d[k] = c6[act6[SRCB_LSB +: IDX_W]];
        assign opb4_d[k] = c4[act4[SRCB_LSB +: IDX_W]];
        assign opb2_d[k] = c2[act2[SRCB_LSB +: IDX_W]];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_o <= phv_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            opa6_o   <= opa6_d;
            opb6_o   <= opb6_d;
            opa4_o   <= opa4_d;
            opb4_o   <= opb4_d;
            opa2_o   <= opa2_d;
            opb2_o   <= opb2_d;
            meta_o   <= phv_i[META_W-1:0];
            action_o <= action_i;
        end
    end

    // a stall must freeze the pipeline, no new item may appear
    a_no_valid_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(valid_o) |-> $past(adv_i)
    );

endmodule

`default_nettype wire

// ==== logic/container_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module container_alu
    import rmt_pkg::*;
#(
    parameter type cont_t = logic [C2_W-1:0]
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             adv_i,
    input  logic [ACT_W-1:0] action_i,
    input  cont_t            opa_i,
    input  cont_t            opb_i,
    output cont_t            cont_o
);

    alu_op_e opcode;
    cont_t   imm;
    cont_t   result;

    assign opcode = alu_op_e'(action_i[OPC_LSB +: OPC_W]);
    // zero extended to the container width
    assign imm    = cont_t'(action_i[IMM_LSB +: IMM_W]);

    // all sums wrap at the container width
    always_comb begin
        case (opcode)
            OP_COPY: result = opa_i;
            OP_ADD:  result = opa_i + opb_i;
            OP_SUB:  result = opa_i - opb_i;
            OP_ADDI: result = opa_i + imm;
            OP_SETI: result = imm;
            // nop and unknown codes, crossbar already put the own value on A
            default: result = opa_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cont_o <= '0;
        end else if (adv_i) begin
            cont_o <= result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/meta_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module meta_alu
    import rmt_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              adv_i,
    input  logic [ACT_W-1:0]  action_i,
    input  logic [META_W-1:0] meta_i,
    input  logic              valid_i,
    output logic [META_W-1:0] meta_o,
    output logic              valid_o
);

    logic [META_W-1:0] meta_d;

    always_comb begin
        meta_d = meta_i;
        case (action_i[OPC_LSB +: OPC_W])
            // output port lives in the low byte
            OP_SETI:    meta_d[7:0] = action_i[IMM_LSB +: 8];
            OP_DISCARD: meta_d[META_W-1] = 1'b1;
            default:    meta_d = meta_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            meta_o <= meta_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/action_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_engine
    import rmt_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              adv_i,
    input  logic [PHV_W-1:0]  phv_i,
    input  logic              phv_valid_i,
    input  logic [ACTV_W-1:0] action_i,
    output logic [PHV_W-1:0]  phv_o,
    output logic              phv_valid_o
);

    cont6_t [NUM_CONT-1:0] opa6;
    cont6_t [NUM_CONT-1:0] opb6;
    cont4_t [NUM_CONT-1:0] opa4;
    cont4_t [NUM_CONT-1:0] opb4;
    cont2_t [NUM_CONT-1:0] opa2;
    cont2_t [NUM_CONT-1:0] opb2;
    cont6_t [NUM_CONT-1:0] res6;
    cont4_t [NUM_CONT-1:0] res4;
    cont2_t [NUM_CONT-1:0] res2;
    logic   [META_W-1:0]   xbar_meta;
    logic   [META_W-1:0]   res_meta;
    logic   [ACTV_W-1:0]   alu_act;
    logic                  xbar_valid;
    logic                  meta_valid;

    action_crossbar xbar_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .adv_i       (adv_i),
        .phv_i       (phv_i),
        .phv_valid_i (phv_valid_i),
        .action_i    (action_i),
        .opa6_o      (opa6),
        .opb6_o      (opb6),
        .opa4_o      (opa4),
        .opb4_o      (opb4),
        .opa2_o      (opa2),
        .opb2_o      (opb2),
        .meta_o      (xbar_meta),
        .action_o    (alu_act),
        .valid_o     (xbar_valid)
    );

    // one ALU per container, action word k drives container k of its class
    for (genvar k = 0; k < NUM_CONT; k++) begin : g_alu
        container_alu #(.cont_t(cont6_t)) alu6_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .adv_i    (adv_i),
            .action_i (alu_act[(2*NUM_CONT + k)*ACT_W +: ACT_W]),
            .opa_i    (opa6[k]),
            .opb_i    (opb6[k]),
            .cont_o   (res6[k])
        );

        container_alu #(.cont_t(cont4_t)) alu4_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .adv_i    (adv_i),
            .action_i (alu_act[(NUM_CONT + k)*ACT_W +: ACT_W]),
            .opa_i    (opa4[k]),
            .opb_i    (opb4[k]),
            .cont_o   (res4[k])
        );

        container_alu #(.cont_t(cont2_t)) alu2_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .adv_i    (adv_i),
            .action_i (alu_act[k*ACT_W +: ACT_W]),
            .opa_i    (opa2[k]),
            .opb_i    (opb2[k]),
            .cont_o   (res2[k])
        );
    end

    meta_alu meta_alu_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .adv_i    (adv_i),
        .action_i (alu_act[META_ACT*ACT_W +: ACT_W]),
        .meta_i   (xbar_meta),
        .valid_i  (xbar_valid),
        .meta_o   (res_meta),
        .valid_o  (meta_valid)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phv_valid_o <= 1'b0;
        end else if (adv_i) begin
            phv_valid_o <= meta_valid;
        end
    end

    // last phv stays on the bus between packets
    always_ff @(posedge clk) begin
        if (adv_i && meta_valid) begin
            phv_o <= {res6, res4, res2, res_meta};
        end
    end

endmodule

`default_nettype wire

// ==== logic/match_action_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module match_action_stage
    import rmt_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [PHV_W-1:0]               phv_i,
    input  logic                           phv_valid_i,
    output logic                           ready_o,
    output logic [PHV_W-1:0]               phv_o,
    output logic                           phv_valid_o,
    input  logic                           ready_i,
    input  logic                           tbl_wr_en_i,
    input  logic [$clog2(TABLE_DEPTH)-1:0] tbl_wr_addr_i,
    input  logic [ACTV_W-1:0]              tbl_wr_data_i
);

    logic [PHV_W-1:0]  lkup_phv;
    logic              lkup_valid;
    logic [ACTV_W-1:0] lkup_action;

    // downstream ready stalls every stage at once
    assign ready_o = ready_i;

    action_lookup #(.TABLE_DEPTH(TABLE_DEPTH)) lookup_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .adv_i         (ready_i),
        .phv_i         (phv_i),
        .phv_valid_i   (phv_valid_i),
        .tbl_wr_en_i   (tbl_wr_en_i),
        .tbl_wr_addr_i (tbl_wr_addr_i),
        .tbl_wr_data_i (tbl_wr_data_i),
        .phv_o         (lkup_phv),
        .phv_valid_o   (lkup_valid),
        .action_o      (lkup_action)
    );

    action_engine engine_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .adv_i       (ready_i),
        .phv_i       (lkup_phv),
        .phv_valid_i (lkup_valid),
        .action_i    (lkup_action),
        .phv_o       (phv_o),
        .phv_valid_o (phv_valid_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_match_action_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_match_action_stage
    import rmt_pkg::*;
();

    localparam int TABLE_DEPTH  = 16;
    localparam int ADDR_W       = $clog2(TABLE_DEPTH);
    localparam int LATENCY      = 4;
    localparam int N_ARITH      = 64;
    localparam int N_BP         = 300;
    localparam int DRAIN_LIMIT  = 64;
    // each table round writes 16 entries, sends up to 16 packets and drains
    localparam int TABLE_ROUNDS = 8;
    localparam int STIM_CYCLES  = 4 * (N_ARITH + N_BP) + TABLE_ROUNDS * 68;
    localparam int TIMEOUT      = 10 * STIM_CYCLES;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [PHV_W-1:0]  phv_i;
    logic              phv_valid_i;
    logic              ready_o;
    logic [PHV_W-1:0]  phv_o;
    logic              phv_valid_o;
    logic              ready_i;
    logic              tbl_wr_en_i;
    logic [ADDR_W-1:0] tbl_wr_addr_i;
    logic [ACTV_W-1:0] tbl_wr_data_i;

    logic [ACTV_W-1:0] tbl_copy [TABLE_DEPTH];
    logic [PHV_W-1:0]  exp_q [$];
    logic [15:0]       lfsr_state = 16'd11190;
    int                cycle = 0;
    int                errors = 0;
    int                checks = 0;
    int                sent_count = 0;
    int                recv_count = 0;
    int                last_accept_cycle = 0;
    int                last_out_cycle = 0;

    match_action_stage #(.TABLE_DEPTH(TABLE_DEPTH)) match_action_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_i         (phv_i),
        .phv_valid_i   (phv_valid_i),
        .ready_o       (ready_o),
        .phv_o         (phv_o),
        .phv_valid_o   (phv_valid_o),
        .ready_i       (ready_i),
        .tbl_wr_en_i   (tbl_wr_en_i),
        .tbl_wr_addr_i (tbl_wr_addr_i),
        .tbl_wr_data_i (tbl_wr_data_i)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [PHV_W-1:0] rand_phv();
        logic [PHV_W-1:0] p;
        for (int i = 0; i < PHV_W / 32; i++) begin
            p[i*32 +: 32] = 32'(rand_bits(32));
        end
        return p;
    endfunction

    function automatic logic [PHV_W-1:0] phv_with_key(int key);
        logic [PHV_W-1:0] p;
        p = rand_phv();
        p[C2_LSB +: KEY_W] = KEY_W'(key);
        return p;
    endfunction

    function automatic logic [ACT_W-1:0] make_word(logic [3:0] op, logic [1:0] sa,
                                                   logic [1:0] sb, logic [15:0] imm);
        return {op, sa, sb, 1'b0, imm};
    endfunction

    // 4'hf is not a defined opcode and must behave as nop
    function automatic logic [3:0] rand_alu_op();
        logic [3:0] op;
        case (3'(rand_bits(3)))
            3'd0:    op = OP_NOP;
            3'd1:    op = OP_COPY;
            3'd2:    op = OP_ADD;
            3'd3:    op = OP_SUB;
            3'd4:    op = OP_ADDI;
            3'd5:    op = OP_SETI;
            3'd6:    op = OP_ADD;
            default: op = 4'hf;
        endcase
        return op;
    endfunction

    function automatic logic [3:0] rand_meta_op();
        logic [3:0] op;
        case (2'(rand_bits(2)))
            2'd0:    op = OP_NOP;
            2'd1:    op = OP_SETI;
            2'd2:    op = OP_DISCARD;
            default: op = 4'hf;
        endcase
        return op;
    endfunction

    function automatic logic [ACTV_W-1:0] rand_actv();
        logic [ACTV_W-1:0] av;
        logic [3:0]        op;
        logic [1:0]        sa;
        logic [1:0]        sb;
        logic [15:0]       imm;
        for (int i = 0; i < NUM_ACT; i++) begin
            op  = (i == META_ACT) ? rand_meta_op() : rand_alu_op();
            sa  = 2'(rand_bits(2));
            sb  = 2'(rand_bits(2));
            imm = 16'(rand_bits(16));
            av[i*ACT_W +: ACT_W] = make_word(op, sa, sb, imm);
        end
        return av;
    endfunction

    function automatic logic [63:0] width_mask(int width);
        return (64'd1 << width) - 64'd1;
    endfunction

    // class 0 is 6B, 1 is 4B, 2 is 2B
    function automatic int class_lsb(int c);
        return (c == 0) ? C6_LSB : (c == 1) ? C4_LSB : C2_LSB;
    endfunction

    function automatic int class_width(int c);
        return (c == 0) ? C6_W : (c == 1) ? C4_W : C2_W;
    endfunction

    function automatic logic [63:0] get_cont(logic [PHV_W-1:0] p, int lsb, int width, int j);
        logic [PHV_W-1:0] s;
        s = p >> (lsb + j * width);
        return s[63:0] & width_mask(width);
    endfunction

    function automatic logic [PHV_W-1:0] set_cont(logic [PHV_W-1:0] p, int pos, int width,
                                                  logic [63:0] v);
        logic [PHV_W-1:0] m;
        m = PHV_W'(width_mask(width)) << pos;
        return (p & ~m) | ((PHV_W'(v) << pos) & m);
    endfunction

    function automatic logic [63:0] alu_ref(logic [ACT_W-1:0] w, logic [63:0] own,
                                            logic [63:0] a, logic [63:0] b, int width);
        logic [63:0] imm;
        logic [63:0] r;
        imm = 64'(w[IMM_LSB +: IMM_W]);
        case (w[OPC_LSB +: OPC_W])
            OP_COPY: r = a;
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_ADDI: r = a + imm;
            OP_SETI: r = imm;
            default: r = own;
        endcase
        return r & width_mask(width);
    endfunction

    // expected output phv from the input phv and its action vector
    function automatic logic [PHV_W-1:0] expect_phv(logic [PHV_W-1:0] p,
                                                    logic [ACTV_W-1:0] av);
        logic [PHV_W-1:0]  r;
        logic [ACT_W-1:0]  w;
        logic [META_W-1:0] m;
        int                lsb;
        int                width;
        r = p;
        for (int c = 0; c < 3; c++) begin
            lsb   = class_lsb(c);
            width = class_width(c);
            for (int k = 0; k < NUM_CONT; k++) begin
                w = av[((2 - c) * NUM_CONT + k) * ACT_W +: ACT_W];
                r = set_cont(r, lsb + k * width, width,
                             alu_ref(w, get_cont(p, lsb, width, k),
                                     get_cont(p, lsb, width, int'(w[SRCA_LSB +: IDX_W])),
                                     get_cont(p, lsb, width, int'(w[SRCB_LSB +: IDX_W])),
                                     width));
            end
        end
        w = av[META_ACT*ACT_W +: ACT_W];
        m = p[META_W-1:0];
        if (w[OPC_LSB +: OPC_W] == OP_SETI) begin
            m[7:0] = w[7:0];
        end else if (w[OPC_LSB +: OPC_W] == OP_DISCARD) begin
            m[31] = 1'b1;
        end
        r[META_W-1:0] = m;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_phv(input logic [PHV_W-1:0] expected, input logic [PHV_W-1:0] actual);
        int lsb;
        int width;
        for (int c = 0; c < 3; c++) begin
            lsb   = class_lsb(c);
            width = class_width(c);
            for (int k = 0; k < NUM_CONT; k++) begin
                check_value($sformatf("phv_o c%0d[%0d]", width / 8, k),
                            get_cont(expected, lsb, width, k), get_cont(actual, lsb, width, k));
            end
        end
        check_value("phv_o meta", 64'(expected[META_W-1:0]), 64'(actual[META_W-1:0]));
    endtask

    task automatic write_entry(input logic [ADDR_W-1:0] addr, input logic [ACTV_W-1:0] data);
        tbl_wr_en_i   = 1'b1;
        tbl_wr_addr_i = addr;
        tbl_wr_data_i = data;
        @(posedge clk);
        #1;
        tbl_wr_en_i = 1'b0;
    endtask

    task automatic send_phv(input logic [PHV_W-1:0] p);
        phv_i       = p;
        phv_valid_i = 1'b1;
        @(posedge clk);
        while (!ready_i) begin
            @(posedge clk);
        end
        #1;
        phv_valid_i = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("error at %0t: %0d expected PHVs never came out", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (errors == mark) ? "ok" : "failed", errors - mark);
    endtask

    // accepted inputs against the table copy, writes land after the lookup
    always @(posedge clk) begin
        if (rst_n && phv_valid_i && ready_i) begin
            exp_q.push_back(expect_phv(phv_i, tbl_copy[phv_i[C2_LSB +: KEY_W]]));
            last_accept_cycle = cycle;
            sent_count++;
        end
        if (tbl_wr_en_i) begin
            tbl_copy[tbl_wr_addr_i] = tbl_wr_data_i;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            check_value("ready_o", 64'(ready_i), 64'(ready_o));
            if (phv_valid_o && ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: output PHV with no packet outstanding", $time);
                end else begin
                    compare_phv(exp_q.pop_front(), phv_o);
                    recv_count++;
                    last_out_cycle = cycle;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: run still busy after %0d cycles", cycle);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [ACTV_W-1:0] av;
        logic              pending;
        int                mark;
        int                sent;

        rst_n         = 1'b0;
        phv_i         = '0;
        phv_valid_i   = 1'b0;
        ready_i       = 1'b1;
        tbl_wr_en_i   = 1'b0;
        tbl_wr_addr_i = '0;
        tbl_wr_data_i = '0;

        // reset, idle and first latency
        mark = errors;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_value("phv_valid_o in reset", 64'd0, 64'(phv_valid_o));
            end
        end
        #1;
        rst_n = 1'b1;
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            write_entry(ADDR_W'(a), '0);
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            check_value("phv_valid_o idle", 64'd0, 64'(phv_valid_o));
        end
        #1;
        send_phv(rand_phv());
        drain_outputs();
        check_value("latency", 64'(LATENCY), 64'(last_out_cycle - last_accept_cycle));
        report_test(1, "reset and latency", mark);

        // pass through, then copies inside each class
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            send_phv(rand_phv());
        end
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            av = '0;
            for (int i = 0; i < META_ACT; i++) begin
                av[i*ACT_W +: ACT_W] = make_word(OP_COPY, 2'((i + a) % NUM_CONT), 2'd0, 16'd0);
            end
            write_entry(ADDR_W'(a), av);
        end
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            send_phv(phv_with_key(a));
        end
        drain_outputs();
        report_test(2, "nop and copy", mark);

        mark = errors;
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            write_entry(ADDR_W'(a), rand_actv());
        end
        for (int i = 0; i < N_ARITH; i++) begin
            send_phv(rand_phv());
        end
        // all ones wraps every add
        av = '0;
        for (int i = 0; i < META_ACT; i++) begin
            if (i % 2 == 0) begin
                av[i*ACT_W +: ACT_W] = make_word(OP_ADDI, 2'(i % NUM_CONT), 2'd0, 16'hffff);
            end else begin
                av[i*ACT_W +: ACT_W] = make_word(OP_ADD, 2'(i % NUM_CONT), 2'(i % NUM_CONT),
                                                 16'd0);
            end
        end
        write_entry(ADDR_W'(TABLE_DEPTH - 1), av);
        send_phv('1);
        drain_outputs();
        report_test(3, "arithmetic", mark);

        mark = errors;
        for (int a = 0; a < 3; a++) begin
            av = '0;
            case (a)
                0:       av[META_ACT*ACT_W +: ACT_W] = make_word(OP_SETI, 2'd0, 2'd0, 16'ha5c3);
                1:       av[META_ACT*ACT_W +: ACT_W] = make_word(OP_DISCARD, 2'd0, 2'd0, 16'd0);
                default: av[META_ACT*ACT_W +: ACT_W] = make_word(OP_NOP, 2'd0, 2'd0, 16'h00ff);
            endcase
            write_entry(ADDR_W'(a), av);
        end
        for (int i = 0; i < 12; i++) begin
            send_phv(phv_with_key(i % 3));
        end
        drain_outputs();
        report_test(4, "metadata", mark);

        mark = errors;
        for (int r = 0; r < 2; r++) begin
            for (int a = 0; a < TABLE_DEPTH; a++) begin
                write_entry(ADDR_W'(a), rand_actv());
            end
            for (int a = 0; a < TABLE_DEPTH; a++) begin
                send_phv(phv_with_key(r == 0 ? a : TABLE_DEPTH - 1 - a));
            end
        end
        // write and lookup on one edge, the lookup still gets the old entry
        tbl_wr_en_i   = 1'b1;
        tbl_wr_addr_i = ADDR_W'(3);
        tbl_wr_data_i = rand_actv();
        send_phv(phv_with_key(3));
        tbl_wr_en_i = 1'b0;
        send_phv(phv_with_key(3));
        drain_outputs();
        report_test(5, "table rewrite", mark);

        mark = errors;
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            write_entry(ADDR_W'(a), rand_actv());
        end
        pending = 1'b0;
        sent    = 0;
        while (sent < N_BP) begin
            if (!pending) begin
                phv_i       = rand_phv();
                phv_valid_i = (2'(rand_bits(2)) != 2'd0);
                pending     = phv_valid_i;
            end
            ready_i = (2'(rand_bits(2)) != 2'd0);
            @(posedge clk);
            if (phv_valid_i && ready_i) begin
                sent++;
                pending = 1'b0;
            end
            #1;
        end
        phv_valid_i = 1'b0;
        ready_i     = 1'b1;
        drain_outputs();
        report_test(6, "back-pressure", mark);

        // room for any stray output to show up
        repeat (8) @(posedge clk);
        $display("packets sent %0d, received %0d, checks %0d, errors %0d",
                 sent_count, recv_count, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/rmt_pkg.sv
logic/action_lookup.sv
logic/action_crossbar.sv
logic/container_alu.sv
logic/meta_alu.sv
logic/action_engine.sv
logic/match_action_stage.sv
dv/tb_match_action_stage.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the match-action stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_match_action_stage -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0
